// ==== all.f ====
+incdir+.
resampler_cfg_pkg.sv
resampler_types_pkg.sv
ringbuf.sv
mpemu.sv
resampler_core.sv
ringbuffered_resampler.sv
tb_resampler.sv

// ==== mpemu.sv ====
`timescale 1ns/1ns

module mpemu
    import resampler_cfg_pkg::*;
    import resampler_types_pkg::*;
(
    input  logic    clk,
    input  sample_t mpcand_i,
    input  sample_t mplier_i,
    output sample_t mprod_o
);

    sample_t mpcand_q;
    sample_t mplier_q;

    logic signed [47:0] prod_pipe [MULT_LATENCY];

    always_ff @(posedge clk) begin
        mpcand_q <= mpcand_i;
        mplier_q <= mplier_i;

        prod_pipe[0] <= mpcand_q * mplier_q;
        for (int i = 1; i < MULT_LATENCY; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end

        // Q2.46 down to Q1.23, truncated
        mprod_o <= prod_pipe[MULT_LATENCY-1][46:23];
    end

endmodule

// ==== resampler_cfg_pkg.sv ====
package resampler_cfg_pkg;

    // Channels sharing the MAC
    localparam int NUM_CH = 8;
    localparam int CH_W = 3;

    // Filter geometry
    localparam int HALFDEPTH = 16;                 // Taps per wing
    localparam int HALFDEPTH_W = 4;
    localparam int NUM_FIR = 160;                  // Polyphase branches
    localparam int FIR_W = 8;
    localparam int DECIM = 147;                    // Phase step per output sample
    localparam int BANK_ADDR_W = FIR_W + HALFDEPTH_W;

    // Ring buffer addressing
    localparam int OFFSET_W = HALFDEPTH_W + 1;     // Spans both wings
    localparam int RB_LEN = 64;
    localparam int RB_PTR_W = 6;

    // Scheduling
    localparam int TIMESLICE = 64;
    localparam int TIMESLICE_W = 6;

    // Multiplier pipeline
    localparam int MULT_LATENCY = 4;
    localparam int PROD_DELAY = MULT_LATENCY + 2;  // Input and output registers included

    // One wing issues all taps, then drains the multiplier
    localparam int WING_CYCLES = HALFDEPTH + PROD_DELAY;

endpackage

// ==== resampler_core.sv ====
`timescale 1ns/1ns

module resampler_core
    import resampler_cfg_pkg::*;
    import resampler_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Coefficient bank
    output logic [BANK_ADDR_W-1:0] bank_addr_o,
    input  sample_t                bank_data_i,

    // Ring buffers
    output rb_ctrl_t               rb_ctrl_o,
    input  sample_t [NUM_CH-1:0]   rb_data_i,

    // Output requests and results
    input  logic [NUM_CH-1:0]      pop_req_i,
    output out_bus_t               out_o
);

    typedef logic [HALFDEPTH_W:0] wing_cnt_t;

    logic [TIMESLICE_W-1:0] slice_cnt;
    logic [CH_W-1:0] cur_ch;
    logic slice_start;

    logic [NUM_CH-1:0] req_latch;
    logic [NUM_CH-1:0] consume_mask;
    logic serve_q;

    core_state_e state;
    wing_cnt_t wing_cnt;
    logic wing_last;
    logic lwing;

    logic [FIR_W-1:0] phase_mem [NUM_CH];
    logic [FIR_W-1:0] rphase;
    logic [FIR_W-1:0] bank_phase;
    logic phase_wrap;

    logic [HALFDEPTH_W-1:0] tap_idx;
    logic [HALFDEPTH_W-1:0] offset_cnt;

    sample_t mprod;
    logic prod_valid;
    sample_t sum_q;

    // Fixed rotation, one slice per channel
    assign slice_start = (slice_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            slice_cnt <= '0;
            cur_ch <= '0;
        end else begin
            slice_cnt <= slice_cnt + 1'b1;
            if (slice_cnt == TIMESLICE_W'(TIMESLICE - 1)) begin
                cur_ch <= cur_ch + 1'b1;
            end
        end
    end

    // Requests wait for their slice; taken at slice start even if pending pulses merge
    always_comb begin
        consume_mask = '0;
        consume_mask[cur_ch] = slice_start;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_latch <= '0;
            serve_q <= 1'b0;
        end else begin
            req_latch <= pop_req_i | (req_latch & ~consume_mask);
            if (slice_start) begin
                serve_q <= req_latch[cur_ch];
            end
        end
    end

    assign wing_last = (wing_cnt == wing_cnt_t'(WING_CYCLES - 1));
    assign lwing = (state == ST_LWING);

    // Wing sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            wing_cnt <= '0;
        end else if (slice_start) begin
            state <= ST_READY;
        end else begin
            wing_cnt <= wing_cnt + 1'b1;
            case (state)
                ST_READY: begin
                    if (serve_q) begin
                        state <= ST_BEGIN;
                    end
                end
                ST_BEGIN: begin
                    state <= ST_RWING;
                    wing_cnt <= '0;
                end
                ST_RWING: begin
                    if (wing_last) begin
                        state <= ST_PREP;
                    end
                end
                ST_PREP: begin
                    state <= ST_LWING;
                    wing_cnt <= '0;
                end
                ST_LWING: begin
                    if (wing_last) begin
                        state <= ST_END;
                    end
                end
                ST_END: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Phase memory, advanced once per output
    assign phase_wrap = (rphase >= FIR_W'(NUM_FIR - DECIM));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                phase_mem[i] <= '0;
            end
        end else if (state == ST_END) begin
            if (phase_wrap) begin
                phase_mem[cur_ch] <= rphase - FIR_W'(NUM_FIR - DECIM);
            end else begin
                phase_mem[cur_ch] <= rphase + FIR_W'(DECIM);
            end
        end
    end

    // Tap and buffer offset counters
    always_ff @(posedge clk) begin
        offset_cnt <= offset_cnt - 1'b1;
        case (state)
            ST_BEGIN: begin
                rphase <= phase_mem[cur_ch];
                tap_idx <= HALFDEPTH_W'(HALFDEPTH - 1);
                offset_cnt <= HALFDEPTH_W'(HALFDEPTH - 1);
            end
            ST_RWING: tap_idx <= tap_idx - 1'b1;
            ST_PREP: begin
                tap_idx <= '0;
                offset_cnt <= HALFDEPTH_W'(HALFDEPTH - 1);
            end
            ST_LWING: tap_idx <= tap_idx + 1'b1;
            default: ;
        endcase
    end

    // Left wing runs the mirrored phase
    assign bank_phase = lwing ? FIR_W'(NUM_FIR - 1) - rphase : rphase;
    assign bank_addr_o = {bank_phase, tap_idx};

    mpemu u_mpemu (
        .clk      (clk),
        .mpcand_i (rb_data_i[cur_ch]),
        .mplier_i (bank_data_i),
        .mprod_o  (mprod)
    );

    // Products of the 16 issued taps land at counter 6..21
    assign prod_valid = (state == ST_RWING || lwing) && (wing_cnt >= wing_cnt_t'(PROD_DELAY));

    always_ff @(posedge clk) begin
        if (state == ST_BEGIN) begin
            sum_q <= '0;
        end else if (prod_valid) begin
            sum_q <= sum_q + mprod;  // Wraps in 24 bits
        end
    end

    always_comb begin
        rb_ctrl_o.pop = '0;
        rb_ctrl_o.pop[cur_ch] = (state == ST_END) && phase_wrap;
        rb_ctrl_o.offset = {~lwing, offset_cnt};  // Right wing reads the upper half

        out_o.ack = '0;
        out_o.ack[cur_ch] = (state == ST_END);
        out_o.data = sum_q;
    end

endmodule

// ==== resampler_types_pkg.sv ====
package resampler_types_pkg;

    import resampler_cfg_pkg::*;

    // Audio sample, also the Q1.23 coefficient word
    typedef logic signed [23:0] sample_t;

    // Input side, one write strobe per channel
    typedef struct packed {
        logic [NUM_CH-1:0] we;
        sample_t [NUM_CH-1:0] data;
    } in_bus_t;

    // Core to ring buffers
    typedef struct packed {
        logic [NUM_CH-1:0] pop;
        logic [OFFSET_W-1:0] offset;    // Shared by all channels
    } rb_ctrl_t;

    // Output side
    typedef struct packed {
        logic [NUM_CH-1:0] ack;
        sample_t data;
    } out_bus_t;

    // Wing sequencer
    typedef enum logic [2:0] {
        ST_READY,
        ST_BEGIN,
        ST_RWING,
        ST_PREP,
        ST_LWING,
        ST_END,
        ST_IDLE
    } core_state_e;

endpackage

// ==== ringbuf.sv ====
`timescale 1ns/1ns

module ringbuf
    import resampler_cfg_pkg::*;
    import resampler_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                we_i,
    input  sample_t             data_i,

    input  logic                pop_i,
    input  logic [RB_PTR_W-1:0] offset_i,
    output sample_t             data_o
);

    sample_t mem [RB_LEN];

    logic [RB_PTR_W-1:0] wr_ptr;
    logic [RB_PTR_W-1:0] rd_base;
    logic [RB_PTR_W-1:0] rd_addr;

    // Pointers wrap naturally at the buffer depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_base <= '0;
        end else begin
            if (we_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_base <= rd_base + 1'b1;  // Oldest sample dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Random access relative to the read base
    assign rd_addr = rd_base + offset_i;
    assign data_o = mem[rd_addr];

endmodule

// ==== ringbuffered_resampler.sv ====
`timescale 1ns/1ns

module ringbuffered_resampler
    import resampler_cfg_pkg::*;
    import resampler_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Coefficient bank, kept outside
    output logic [BANK_ADDR_W-1:0] bank_addr_o,
    input  sample_t                bank_data_i,

    // Sample input, one strobe per channel
    input  in_bus_t                in_i,

    // Output requests and results
    input  logic [NUM_CH-1:0]      pop_req_i,
    output out_bus_t               out_o
);

    rb_ctrl_t rb_ctrl;
    sample_t [NUM_CH-1:0] rb_data;

    for (genvar g = 0; g < NUM_CH; g++) begin : g_rb
        ringbuf u_ringbuf (
            .clk      (clk),
            .rst      (rst),
            .we_i     (in_i.we[g]),
            .data_i   (in_i.data[g]),
            .pop_i    (rb_ctrl.pop[g]),
            .offset_i ({1'b0, rb_ctrl.offset}),
            .data_o   (rb_data[g])
        );
    end

    resampler_core u_core (
        .clk         (clk),
        .rst         (rst),
        .bank_addr_o (bank_addr_o),
        .bank_data_i (bank_data_i),
        .rb_ctrl_o   (rb_ctrl),
        .rb_data_i   (rb_data),
        .pop_req_i   (pop_req_i),
        .out_o       (out_o)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the resampler testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -f all.f --top-module tb_resampler -o tb_resampler
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_resampler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== tb_resampler_tasks.svh ====
// Bank contents per phase and tap
function automatic sample_t coef_of(input int phase, input int tap);
    int raw;
    raw = ((phase * HALFDEPTH + tap) * COEF_STEP) % 4096 - 2048;
    return sample_t'(raw);
endfunction

// Q1.23 product with low bits dropped
function automatic sample_t trunc_prod(input sample_t a, input sample_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return sample_t'(p >>> 23);
endfunction

function automatic sample_t expected_sum(input logic [CH_W-1:0] ch);
    sample_t acc;
    logic [RB_PTR_W-1:0] ridx;
    logic [RB_PTR_W-1:0] lidx;
    int ph;
    acc = '0;
    ph = model_phase[ch];
    for (int d = 0; d < HALFDEPTH; d++) begin
        ridx = model_base[ch] + RB_PTR_W'(HALFDEPTH + d);
        lidx = model_base[ch] + RB_PTR_W'(HALFDEPTH - 1 - d);
        acc = acc + trunc_prod(model_mem[ch][ridx], coef_of(ph, d));
        acc = acc + trunc_prod(model_mem[ch][lidx], coef_of(NUM_FIR - 1 - ph, d));
    end
    return acc;
endfunction

function automatic int next_slice_of(input logic [CH_W-1:0] ch, input int from_slice);
    int t;
    t = from_slice + 1;
    while ((t % NUM_CH) != int'(ch)) begin
        t++;
    end
    return t;
endfunction

task automatic init_model();
    for (int c = 0; c < NUM_CH; c++) begin
        model_wr[c] = '0;
        model_base[c] = '0;
        model_phase[c] = 0;
        for (int a = 0; a < RB_LEN; a++) begin
            model_mem[c][a] = '0;
        end
    end
endtask

// Phase step and pop rule per output
task automatic advance_model(input logic [CH_W-1:0] ch);
    if (model_phase[ch] >= NUM_FIR - DECIM) begin
        model_phase[ch] = model_phase[ch] - (NUM_FIR - DECIM);
        model_base[ch] = model_base[ch] + 1'b1;
    end else begin
        model_phase[ch] = model_phase[ch] + DECIM;
    end
endtask

task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_val(input string name, input logic signed [31:0] expected,
                         input logic signed [31:0] actual);
    if (actual !== expected) begin
        $display("Error: time %0t, %s expected %0d, got %0d", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic load_samples(input logic [NUM_CH-1:0] mask, input int count);
    logic [CH_W-1:0] ch;
    sample_t smp;
    for (int n = 0; n < count; n++) begin
        in_bus.we = mask;
        for (int c = 0; c < NUM_CH; c++) begin
            ch = CH_W'(c);
            smp = sample_t'($random(seed) & 32'h00FF_F000);  // 12 significant bits
            in_bus.data[ch] = smp;
            if (mask[ch]) begin
                model_mem[ch][model_wr[ch]] = smp;
                model_wr[ch] = model_wr[ch] + 1'b1;
            end
        end
        @(negedge clk);
    end
    in_bus.we = '0;
endtask

task automatic pulse_request(input logic [NUM_CH-1:0] mask, output int slice_no);
    slice_no = run_cycles / TIMESLICE;
    pop_req = mask;
    @(negedge clk);
    pop_req = '0;
endtask

task automatic wait_slice(input logic [CH_W-1:0] ch, input int pos);
    bit there;
    there = 1'b0;
    while (!there) begin
        there = ((run_cycles / TIMESLICE) % NUM_CH == int'(ch))
                && (run_cycles % TIMESLICE == pos);
        if (!there) begin
            @(negedge clk);
        end
    end
endtask

task automatic wait_ack(output logic [NUM_CH-1:0] ack, output sample_t data);
    int n;
    n = 0;
    ack = '0;
    data = '0;
    while (ack == '0) begin
        @(negedge clk);
        n++;
        if (dut_out.ack != '0) begin
            ack = dut_out.ack;
            data = dut_out.data;
        end else if (n >= ACK_WAIT) begin
            $display("No output ack arrived within %0d cycles", ACK_WAIT);
            abort_run();
        end
    end
endtask

task automatic expect_output(input logic [CH_W-1:0] ch, input int exp_slice);
    logic [NUM_CH-1:0] ack;
    logic [NUM_CH-1:0] exp_ack;
    sample_t data;
    sample_t exp_data;
    wait_ack(ack, data);
    exp_ack = '0;
    exp_ack[ch] = 1'b1;
    exp_data = expected_sum(ch);
    check_val("out_o.ack", 32'(exp_ack), 32'(ack));
    check_val("ack slice number", exp_slice, run_cycles / TIMESLICE);
    check_val("ack cycle in slice", ACK_POS, run_cycles % TIMESLICE);
    check_val("out_o.data", 32'(exp_data), 32'(data));
    advance_model(ch);
endtask

task automatic expect_quiet(input int cycles);
    for (int n = 0; n < cycles; n++) begin
        @(negedge clk);
        check_val("out_o.ack", 0, 32'(dut_out.ack));
    end
endtask

task automatic idle_rotation_quiet();
    expect_quiet(NUM_CH * TIMESLICE);
endtask

task automatic single_request_ch3();
    int s;
    load_samples('1, 40);
    pulse_request(8'h08, s);
    expect_output(3'd3, next_slice_of(3'd3, s));
    expect_quiet(NUM_CH * TIMESLICE);   // Only one ack
endtask

task automatic phase_steps_ch3();
    int s;
    load_samples(8'h08, 24);            // Read window moves up with each pop
    for (int n = 0; n < 10; n++) begin
        pulse_request(8'h08, s);
        expect_output(3'd3, next_slice_of(3'd3, s));
    end
endtask

task automatic all_channels_together();
    int s;
    logic [CH_W-1:0] ch;
    pulse_request('1, s);
    for (int k = 1; k <= NUM_CH; k++) begin
        ch = CH_W'((s + k) % NUM_CH);
        expect_output(ch, s + k);
    end
endtask

task automatic merged_and_late_requests();
    int s;
    wait_slice(3'd6, 0);
    pulse_request(8'h20, s);
    repeat (3) @(negedge clk);
    pulse_request(8'h20, s);
    expect_output(3'd5, next_slice_of(3'd5, s));
    expect_quiet(NUM_CH * TIMESLICE);
    // Slice already started so it waits a rotation
    wait_slice(3'd5, 8);
    pulse_request(8'h20, s);
    expect_output(3'd5, s + NUM_CH);
endtask

// ==== tb_resampler.sv ====
`timescale 1ns/1ns

module tb_resampler
    import resampler_cfg_pkg::*;
    import resampler_types_pkg::*;
();

    localparam int MAX_CYCLES = 20000;     // Roughly 200 slices of tests plus margin
    localparam int ACK_POS = 48;           // END state relative to slice start
    localparam int ACK_WAIT = 10 * TIMESLICE;
    localparam int COEF_STEP = 37;

    logic clk;
    logic rst;

    logic [BANK_ADDR_W-1:0] bank_addr;
    sample_t bank_data;
    in_bus_t in_bus;
    logic [NUM_CH-1:0] pop_req;
    out_bus_t dut_out;

    int cycle_cnt = 0;
    int run_cycles = 0;     // Tracks the DUT slice counter
    integer seed = 75;

    // Reference model state per channel
    sample_t model_mem [NUM_CH][RB_LEN];
    logic [RB_PTR_W-1:0] model_wr [NUM_CH];
    logic [RB_PTR_W-1:0] model_base [NUM_CH];
    int model_phase [NUM_CH];

    `include "tb_resampler_tasks.svh"

    ringbuffered_resampler UUT (
        .clk         (clk),
        .rst         (rst),
        .bank_addr_o (bank_addr),
        .bank_data_i (bank_data),
        .in_i        (in_bus),
        .pop_req_i   (pop_req),
        .out_o       (dut_out)
    );

    // Combinational coefficient bank
    assign bank_data = coef_of(int'(bank_addr[BANK_ADDR_W-1:HALFDEPTH_W]),
                               int'(bank_addr[HALFDEPTH_W-1:0]));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    initial begin
        rst = 1'b1;
        in_bus = '0;
        pop_req = '0;
        init_model();

        repeat (2) @(negedge clk);
        rst = 1'b0;

        idle_rotation_quiet();
        single_request_ch3();
        phase_steps_ch3();
        all_channels_together();
        merged_and_late_requests();

        repeat (4) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
